/* rtl/cu_defs.svh */
`ifndef CU_DEFS_SVH
`define CU_DEFS_SVH

// instruction field widths
`define CU_OPCODE_W    6
`define CU_FUNCT_W     6
`define CU_REG_IDX_W   5
`define CU_INSTR_W     32

// width of the ALU operation select
`define CU_ALU_CTRL_W  4

// wait cycles before memory read data is valid
`define CU_MEM_LATENCY 2
// must hold CU_MEM_LATENCY - 1
`define CU_TIMER_W     3

`endif

/* rtl/cuIsaPkg.sv */
`default_nettype none
`include "cu_defs.svh"

package cuIsaPkg;

    // one fetched word, read as R-type or as I-type
    typedef union packed
    {
        struct packed
        {
            logic [`CU_OPCODE_W-1:0]  opcode;
            logic [`CU_REG_IDX_W-1:0] rs;
            logic [`CU_REG_IDX_W-1:0] rt;
            logic [`CU_REG_IDX_W-1:0] rd;
            // shift amount, unused by the kept instructions
            logic [`CU_REG_IDX_W-1:0] shamt;
            logic [`CU_FUNCT_W-1:0]   funct;
        } rType;
        struct packed
        {
            logic [`CU_OPCODE_W-1:0]  opcode;
            logic [`CU_REG_IDX_W-1:0] rs;
            logic [`CU_REG_IDX_W-1:0] rt;
            // offset for lw / sw
            logic [`CU_INSTR_W-`CU_OPCODE_W-2*`CU_REG_IDX_W-1:0] immediate;
        } iType;
    } instr_u;

    // primary opcodes that are decoded
    typedef enum logic [`CU_OPCODE_W-1:0]
    {
        opRType = 6'h00,
        opLw    = 6'h23,
        opSw    = 6'h2B
    } opcode_e;

    // funct codes under the R-type opcode
    typedef enum logic [`CU_FUNCT_W-1:0]
    {
        functAdd = 6'h20,
        functSub = 6'h22,
        functAnd = 6'h24,
        functOr  = 6'h25,
        functSlt = 6'h2A
    } funct_e;

    // ALU operation codes as seen by the datapath
    typedef enum logic [`CU_ALU_CTRL_W-1:0]
    {
        aluAnd = 4'd0,
        aluOr  = 4'd1,
        aluAdd = 4'd2,
        aluSub = 4'd6,
        aluSlt = 4'd7
    } aluOp_e;

    typedef enum logic [1:0]
    {
        classRType,
        classLoad,
        classStore,
        classIllegal
    } instrClass_e;

    // latched result of decoding one word
    typedef struct packed
    {
        instrClass_e              instrClass;
        aluOp_e                   aluOp;
        logic [`CU_REG_IDX_W-1:0] destReg;
    } decoded_t;

endpackage

`default_nettype wire

/* rtl/cuCtrlPkg.sv */
`default_nettype none
`include "cu_defs.svh"

package cuCtrlPkg;

    // one state per machine phase
    typedef enum logic [3:0]
    {
        phaseIdle,
        // waits on instruction memory
        phaseFetchWait,
        phaseFetch,
        // decode and dispatch in one step
        phaseDecode,
        phaseExecute,
        phaseWriteBack,
        // effective address for lw and sw
        phaseAddress,
        phaseStore,
        // waits on data memory
        phaseLoadWait,
        phaseLoad,
        phaseLoadBack
    } phase_e;

    // second ALU operand select
    typedef enum logic [1:0]
    {
        srcBRegB      = 2'd0,
        srcBFour      = 2'd1,
        srcBImmediate = 2'd2
    } srcB_e;

    // strobes and selects toward the datapath
    typedef struct packed
    {
        logic                      pcEn;
        // address mux, 0 pc, 1 alu out
        logic                      iorD;
        // 0 rom, 1 ram
        logic                      memSelect;
        logic                      memWrite;
        logic                      irWrite;
        // read data register enable
        logic                      dataWrite;
        // write data mux, 0 alu out, 1 read data
        logic                      memToReg;
        logic                      regWrite;
        // RD1 / RD2 holding registers
        logic                      rdxEn;
        // 0 pc, 1 register A
        logic                      aluSrcA;
        srcB_e                     aluSrcB;
        logic [`CU_ALU_CTRL_W-1:0] aluCtrl;
        logic                      aluOutEn;
    } ctrlWord_t;

endpackage

`default_nettype wire

/* rtl/instrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cu_defs.svh"

module instrDecoder
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire cuIsaPkg::instr_u instr,
    input  wire                 irWrite,
    output cuIsaPkg::decoded_t  decoded
);

    // decode of the word currently on the bus
    cuIsaPkg::decoded_t decodeNext;

    always_comb
    begin
        // anything unrecognised falls to illegal
        decodeNext.instrClass = cuIsaPkg::classIllegal;
        decodeNext.aluOp      = cuIsaPkg::aluAdd;
        decodeNext.destReg    = '0;

        // opcode sits in the same bits in both views
        case (instr.iType.opcode)
            cuIsaPkg::opRType:
            begin
                decodeNext.instrClass = cuIsaPkg::classRType;
                // R-type writes rd
                decodeNext.destReg    = instr.rType.rd;
                case (instr.rType.funct)
                    cuIsaPkg::functAdd:
                        decodeNext.aluOp = cuIsaPkg::aluAdd;
                    cuIsaPkg::functSub:
                        decodeNext.aluOp = cuIsaPkg::aluSub;
                    cuIsaPkg::functAnd:
                        decodeNext.aluOp = cuIsaPkg::aluAnd;
                    cuIsaPkg::functOr:
                        decodeNext.aluOp = cuIsaPkg::aluOr;
                    cuIsaPkg::functSlt:
                        decodeNext.aluOp = cuIsaPkg::aluSlt;
                    // bad funct under a valid opcode
                    default:
                        decodeNext.instrClass = cuIsaPkg::classIllegal;
                endcase
            end
            cuIsaPkg::opLw:
            begin
                decodeNext.instrClass = cuIsaPkg::classLoad;
                // load target is rt
                decodeNext.destReg    = instr.iType.rt;
            end
            cuIsaPkg::opSw:
            begin
                // sw writes no register
                decodeNext.instrClass = cuIsaPkg::classStore;
            end
            default:
            begin
                decodeNext.instrClass = cuIsaPkg::classIllegal;
            end
        endcase
    end

    // latch on the clock that ends fetch
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            decoded <= '0;
        end
        else if (irWrite)
        begin
            decoded <= decodeNext;
        end
    end

endmodule

`default_nettype wire

/* rtl/accessTimer.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cu_defs.svh"

module accessTimer
(
    input  wire  clk,
    input  wire  reset,
    input  wire  timerStart,
    output logic timerDone
);

    logic [`CU_TIMER_W-1:0] count;
    // set while a wait is being measured
    logic                   active;

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            count  <= '0;
            active <= 1'b0;
        end
        else if (timerStart)
        begin
            // first wait cycle already counts
            count  <= `CU_TIMER_W'(`CU_MEM_LATENCY - 1);
            active <= 1'b1;
        end
        else if (active)
        begin
            if (count == '0)
            begin
                active <= 1'b0;
            end
            else
            begin
                count <= count - 1'b1;
            end
        end
    end

    // high in the last wait cycle
    assign timerDone = active && (count == '0);

endmodule

`default_nettype wire

/* rtl/phaseSequencer.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cu_defs.svh"

module phaseSequencer
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       run,
    input  wire                       timerDone,
    input  wire cuIsaPkg::instrClass_e instrClass,
    output cuCtrlPkg::phase_e         phase,
    output cuCtrlPkg::phase_e         nextPhase,
    output logic                      timerStart
);

    always_comb
    begin
        nextPhase = phase;
        case (phase)
            cuCtrlPkg::phaseIdle:
            begin
                // run only looked at here
                if (run)
                begin
                    nextPhase = cuCtrlPkg::phaseFetchWait;
                end
            end
            cuCtrlPkg::phaseFetchWait:
            begin
                if (timerDone)
                begin
                    nextPhase = cuCtrlPkg::phaseFetch;
                end
            end
            cuCtrlPkg::phaseFetch:
                nextPhase = cuCtrlPkg::phaseDecode;
            cuCtrlPkg::phaseDecode:
            begin
                // class is valid here, latched at end of fetch
                case (instrClass)
                    cuIsaPkg::classRType:
                        nextPhase = cuCtrlPkg::phaseExecute;
                    cuIsaPkg::classLoad,
                    cuIsaPkg::classStore:
                        nextPhase = cuCtrlPkg::phaseAddress;
                    // illegal word, just fetch the next one
                    default:
                        nextPhase = cuCtrlPkg::phaseFetchWait;
                endcase
            end
            cuCtrlPkg::phaseExecute:
                nextPhase = cuCtrlPkg::phaseWriteBack;
            cuCtrlPkg::phaseWriteBack:
                nextPhase = cuCtrlPkg::phaseFetchWait;
            cuCtrlPkg::phaseAddress:
            begin
                // only lw and sw reach address
                if (instrClass == cuIsaPkg::classLoad)
                begin
                    nextPhase = cuCtrlPkg::phaseLoadWait;
                end
                else
                begin
                    nextPhase = cuCtrlPkg::phaseStore;
                end
            end
            cuCtrlPkg::phaseStore:
                nextPhase = cuCtrlPkg::phaseFetchWait;
            cuCtrlPkg::phaseLoadWait:
            begin
                if (timerDone)
                begin
                    nextPhase = cuCtrlPkg::phaseLoad;
                end
            end
            cuCtrlPkg::phaseLoad:
                nextPhase = cuCtrlPkg::phaseLoadBack;
            cuCtrlPkg::phaseLoadBack:
                nextPhase = cuCtrlPkg::phaseFetchWait;
            default:
                nextPhase = cuCtrlPkg::phaseIdle;
        endcase
    end

    // start the wait count on entry to either wait phase
    assign timerStart = (nextPhase != phase) &&
                        ((nextPhase == cuCtrlPkg::phaseFetchWait) ||
                         (nextPhase == cuCtrlPkg::phaseLoadWait));

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            phase <= cuCtrlPkg::phaseIdle;
        end
        else
        begin
            phase <= nextPhase;
        end
    end

endmodule

`default_nettype wire

/* rtl/controlWordGen.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cu_defs.svh"

module controlWordGen
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire cuCtrlPkg::phase_e nextPhase,
    input  wire cuIsaPkg::aluOp_e  aluOp,
    output cuCtrlPkg::ctrlWord_t   ctrl
);

    // word for the phase about to start
    cuCtrlPkg::ctrlWord_t nextWord;

    always_comb
    begin
        // every bit not named below stays low
        nextWord = '0;
        case (nextPhase)
            cuCtrlPkg::phaseFetch:
            begin
                // pc + 4 and instruction latch
                nextWord.pcEn    = 1'b1;
                nextWord.irWrite = 1'b1;
                nextWord.aluSrcB = cuCtrlPkg::srcBFour;
                nextWord.aluCtrl = cuIsaPkg::aluAdd;
            end
            cuCtrlPkg::phaseDecode:
            begin
                // register file read into A / B
                nextWord.rdxEn   = 1'b1;
                nextWord.aluSrcA = 1'b1;
            end
            cuCtrlPkg::phaseExecute:
            begin
                nextWord.aluSrcA  = 1'b1;
                nextWord.aluSrcB  = cuCtrlPkg::srcBRegB;
                // decoded op, valid since decode
                nextWord.aluCtrl  = aluOp;
                nextWord.aluOutEn = 1'b1;
            end
            cuCtrlPkg::phaseWriteBack:
            begin
                nextWord.regWrite = 1'b1;
            end
            cuCtrlPkg::phaseAddress:
            begin
                // base + offset
                nextWord.rdxEn    = 1'b1;
                nextWord.aluSrcA  = 1'b1;
                nextWord.aluSrcB  = cuCtrlPkg::srcBImmediate;
                nextWord.aluCtrl  = cuIsaPkg::aluAdd;
                nextWord.aluOutEn = 1'b1;
            end
            cuCtrlPkg::phaseStore:
            begin
                nextWord.iorD      = 1'b1;
                nextWord.memSelect = 1'b1;
                nextWord.memWrite  = 1'b1;
            end
            cuCtrlPkg::phaseLoadWait:
            begin
                // hold the ram address while waiting
                nextWord.iorD      = 1'b1;
                nextWord.memSelect = 1'b1;
            end
            cuCtrlPkg::phaseLoad:
            begin
                nextWord.iorD      = 1'b1;
                nextWord.memSelect = 1'b1;
                nextWord.dataWrite = 1'b1;
            end
            cuCtrlPkg::phaseLoadBack:
            begin
                nextWord.memToReg = 1'b1;
                nextWord.regWrite = 1'b1;
            end
            default:
            begin
                nextWord = '0;
            end
        endcase
    end

    // registered on the same edge as the phase register
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            ctrl <= '0;
        end
        else
        begin
            ctrl <= nextWord;
        end
    end

endmodule

`default_nettype wire

/* rtl/controlUnitTop.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cu_defs.svh"

module controlUnitTop
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       run,
    input  wire cuIsaPkg::instr_u     instr,
    output cuCtrlPkg::ctrlWord_t      ctrl,
    output logic [`CU_REG_IDX_W-1:0]  destReg,
    output cuCtrlPkg::phase_e         phase
);

    cuIsaPkg::decoded_t decoded;
    // phase one clock ahead, feeds the control word register
    cuCtrlPkg::phase_e  nextPhase;
    logic               timerStart;
    logic               timerDone;

    instrDecoder decoder
    (
        .clk     (clk),
        .reset   (reset),
        .instr   (instr),
        // latch strobe comes back from the control word
        .irWrite (ctrl.irWrite),
        .decoded (decoded)
    );

    accessTimer timer
    (
        .clk        (clk),
        .reset      (reset),
        .timerStart (timerStart),
        .timerDone  (timerDone)
    );

    phaseSequencer sequencer
    (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .timerDone  (timerDone),
        .instrClass (decoded.instrClass),
        .phase      (phase),
        .nextPhase  (nextPhase),
        .timerStart (timerStart)
    );

    controlWordGen wordGen
    (
        .clk       (clk),
        .reset     (reset),
        .nextPhase (nextPhase),
        .aluOp     (decoded.aluOp),
        .ctrl      (ctrl)
    );

    // register file write address
    assign destReg = decoded.destReg;

endmodule

`default_nettype wire

/* dv/tbControlUnit.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cu_defs.svh"

module tbControlUnit;

    localparam int memLatency = `CU_MEM_LATENCY;
    localparam int numInstr   = 40;
    // every instruction a lw, plus margin for reset and idle
    localparam int cycleLimit = numInstr * (2 * memLatency + 5) + 50;

    logic                     clk;
    logic                     reset;
    logic                     run;
    cuIsaPkg::instr_u         instr;
    cuCtrlPkg::ctrlWord_t     ctrl;
    logic [`CU_REG_IDX_W-1:0] destReg;
    cuCtrlPkg::phase_e        phase;

    // reference model state
    cuCtrlPkg::phase_e        mPhase;
    int                       mWait;
    cuIsaPkg::instrClass_e    mClass;
    logic [3:0]               mAluOp;
    logic [4:0]               mDest;
    logic [31:0]              mWord;

    // per instruction, bounded by DUT entries to fetchWait
    cuCtrlPkg::phase_e        lastPhase;
    int                       insCycles;
    int                       pcPulses;
    int                       irPulses;
    int                       insErrStart;
    int                       errors;
    int                       checks;
    int                       cycleCount;
    int                       doneCount;
    int                       testsFailed;
    integer                   seed;

    controlUnitTop UUT
    (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .instr   (instr),
        .ctrl    (ctrl),
        .destReg (destReg),
        .phase   (phase)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #4 clk = ~clk;
        end
    end

    // random word from the mix, fields placed per the MIPS layout
    task drawWord(output cuIsaPkg::instr_u w);
        logic [31:0] r;
        int          pick;
        logic [5:0]  code;
        r    = $random(seed);
        w    = r;
        r    = $random(seed);
        pick = int'(r[7:0] % 8'd10);
        case (pick)
            0, 1, 2, 3:
            begin
                w.rType.opcode = 6'h00;
                case (r[15:8] % 8'd5)
                    8'd0: w.rType.funct = 6'h20;
                    8'd1: w.rType.funct = 6'h22;
                    8'd2: w.rType.funct = 6'h24;
                    8'd3: w.rType.funct = 6'h25;
                    default: w.rType.funct = 6'h2A;
                endcase
            end
            4, 5: w.iType.opcode = 6'h23;
            6, 7: w.iType.opcode = 6'h2B;
            8:
            begin
                // step off the three decoded opcodes
                code = r[21:16];
                while ((code == 6'h00) || (code == 6'h23) || (code == 6'h2B))
                begin
                    code = code + 6'd1;
                end
                w.iType.opcode = code;
            end
            default:
            begin
                // R-type opcode with a funct outside the table
                code = r[21:16];
                while ((code == 6'h20) || (code == 6'h22) || (code == 6'h24) ||
                       (code == 6'h25) || (code == 6'h2A))
                begin
                    code = code + 6'd1;
                end
                w.rType.opcode = 6'h00;
                w.rType.funct  = code;
            end
        endcase
    endtask

    // decode rules straight from the instruction format
    task decodeModel(input logic [31:0] w);
        mWord  = w;
        mClass = cuIsaPkg::classIllegal;
        mAluOp = 4'd2;
        mDest  = 5'd0;
        case (w[31:26])
            6'h00:
            begin
                mClass = cuIsaPkg::classRType;
                mDest  = w[15:11];
                case (w[5:0])
                    6'h20: mAluOp = 4'd2;
                    6'h22: mAluOp = 4'd6;
                    6'h24: mAluOp = 4'd0;
                    6'h25: mAluOp = 4'd1;
                    6'h2A: mAluOp = 4'd7;
                    default: mClass = cuIsaPkg::classIllegal;
                endcase
            end
            6'h23:
            begin
                mClass = cuIsaPkg::classLoad;
                mDest  = w[20:16];
            end
            6'h2B: mClass = cuIsaPkg::classStore;
            default: mClass = cuIsaPkg::classIllegal;
        endcase
    endtask

    task enterWait(input cuCtrlPkg::phase_e p);
        mPhase = p;
        mWait  = memLatency;
    endtask

    // one clock of the model, inputs are stable at the edge
    task stepModel;
        if (!reset)
        begin
            mPhase = cuCtrlPkg::phaseIdle;
            mWait  = 0;
        end
        else
        begin
            case (mPhase)
                cuCtrlPkg::phaseIdle:
                begin
                    if (run)
                    begin
                        enterWait(cuCtrlPkg::phaseFetchWait);
                    end
                end
                cuCtrlPkg::phaseFetchWait,
                cuCtrlPkg::phaseLoadWait:
                begin
                    if (mWait > 1)
                    begin
                        mWait--;
                    end
                    else
                    begin
                        mPhase = (mPhase == cuCtrlPkg::phaseFetchWait) ?
                                 cuCtrlPkg::phaseFetch : cuCtrlPkg::phaseLoad;
                    end
                end
                cuCtrlPkg::phaseFetch:
                begin
                    // word on the bus during fetch is the one latched
                    decodeModel(instr);
                    mPhase = cuCtrlPkg::phaseDecode;
                end
                cuCtrlPkg::phaseDecode:
                begin
                    if (mClass == cuIsaPkg::classRType)
                    begin
                        mPhase = cuCtrlPkg::phaseExecute;
                    end
                    else if (mClass == cuIsaPkg::classIllegal)
                    begin
                        enterWait(cuCtrlPkg::phaseFetchWait);
                    end
                    else
                    begin
                        mPhase = cuCtrlPkg::phaseAddress;
                    end
                end
                cuCtrlPkg::phaseExecute: mPhase = cuCtrlPkg::phaseWriteBack;
                cuCtrlPkg::phaseAddress:
                begin
                    if (mClass == cuIsaPkg::classLoad)
                    begin
                        enterWait(cuCtrlPkg::phaseLoadWait);
                    end
                    else
                    begin
                        mPhase = cuCtrlPkg::phaseStore;
                    end
                end
                cuCtrlPkg::phaseLoad: mPhase = cuCtrlPkg::phaseLoadBack;
                default: enterWait(cuCtrlPkg::phaseFetchWait);
            endcase
        end
    endtask

    // phase table of the control word
    function automatic cuCtrlPkg::ctrlWord_t expectedWord(input cuCtrlPkg::phase_e p,
                                                          input logic [3:0] op);
        cuCtrlPkg::ctrlWord_t w;
        w = '0;
        case (p)
            cuCtrlPkg::phaseFetch:
            begin
                w.pcEn    = 1'b1;
                w.irWrite = 1'b1;
                w.aluSrcB = cuCtrlPkg::srcBFour;
                w.aluCtrl = 4'd2;
            end
            cuCtrlPkg::phaseDecode:
            begin
                w.rdxEn   = 1'b1;
                w.aluSrcA = 1'b1;
            end
            cuCtrlPkg::phaseExecute:
            begin
                w.aluSrcA  = 1'b1;
                w.aluCtrl  = op;
                w.aluOutEn = 1'b1;
            end
            cuCtrlPkg::phaseWriteBack: w.regWrite = 1'b1;
            cuCtrlPkg::phaseAddress:
            begin
                w.rdxEn    = 1'b1;
                w.aluSrcA  = 1'b1;
                w.aluSrcB  = cuCtrlPkg::srcBImmediate;
                w.aluCtrl  = 4'd2;
                w.aluOutEn = 1'b1;
            end
            cuCtrlPkg::phaseStore:
            begin
                w.iorD      = 1'b1;
                w.memSelect = 1'b1;
                w.memWrite  = 1'b1;
            end
            cuCtrlPkg::phaseLoadWait:
            begin
                w.iorD      = 1'b1;
                w.memSelect = 1'b1;
            end
            cuCtrlPkg::phaseLoad:
            begin
                w.iorD      = 1'b1;
                w.memSelect = 1'b1;
                w.dataWrite = 1'b1;
            end
            cuCtrlPkg::phaseLoadBack:
            begin
                w.memToReg = 1'b1;
                w.regWrite = 1'b1;
            end
            default: w = '0;
        endcase
        return w;
    endfunction

    // cycles from fetchWait entry to the next one
    function automatic int expectedLength(input cuIsaPkg::instrClass_e c);
        case (c)
            cuIsaPkg::classRType: return memLatency + 4;
            cuIsaPkg::classStore: return memLatency + 4;
            cuIsaPkg::classLoad: return 2 * memLatency + 5;
            default: return memLatency + 2;
        endcase
    endfunction

    function automatic string className(input cuIsaPkg::instrClass_e c);
        case (c)
            cuIsaPkg::classRType: return "R-type";
            cuIsaPkg::classLoad: return "lw";
            cuIsaPkg::classStore: return "sw";
            default: return "illegal";
        endcase
    endfunction

    task finishInstruction;
        assert (insCycles == expectedLength(mClass))
        else
        begin
            $display("instruction took %0d cycles, expected %0d",
                     insCycles, expectedLength(mClass));
            errors++;
        end
        assert ((pcPulses == 1) && (irPulses == 1))
        else
        begin
            $display("pcEn pulsed %0d times and irWrite %0d times, expected once each",
                     pcPulses, irPulses);
            errors++;
        end
        doneCount++;
        if (errors == insErrStart)
        begin
            $display("test %0d %s word %h: pass", doneCount, className(mClass), mWord);
        end
        else
        begin
            testsFailed++;
            $display("test %0d %s word %h: fail", doneCount, className(mClass), mWord);
        end
    endtask

    // sampled at the falling edge, away from DUT updates
    task checkOutputs;
        cuCtrlPkg::ctrlWord_t expWord;
        expWord = expectedWord(mPhase, mAluOp);
        checks++;
        assert (phase === mPhase)
        else
        begin
            $display("MISMATCH phase: expected %h, got %h at cycle %0d",
                     mPhase, phase, cycleCount);
            errors++;
        end
        assert (ctrl === expWord)
        else
        begin
            $display("MISMATCH ctrl: expected %h, got %h at cycle %0d",
                     expWord, ctrl, cycleCount);
            errors++;
        end
        // write address only matters when a register is written
        if ((mPhase == cuCtrlPkg::phaseWriteBack) || (mPhase == cuCtrlPkg::phaseLoadBack))
        begin
            assert (destReg === mDest)
            else
            begin
                $display("MISMATCH destReg: expected %h, got %h at cycle %0d",
                         mDest, destReg, cycleCount);
                errors++;
            end
        end
        if ((phase == cuCtrlPkg::phaseFetchWait) && (lastPhase != cuCtrlPkg::phaseFetchWait))
        begin
            if (lastPhase != cuCtrlPkg::phaseIdle)
            begin
                finishInstruction();
            end
            insCycles   = 0;
            pcPulses    = 0;
            irPulses    = 0;
            insErrStart = errors;
        end
        if (phase != cuCtrlPkg::phaseIdle)
        begin
            insCycles++;
        end
        if (ctrl.pcEn)
        begin
            pcPulses++;
        end
        if (ctrl.irWrite)
        begin
            irPulses++;
        end
        lastPhase = phase;
    endtask

    task runCycle(input logic nextReset, input logic nextRun);
        cuIsaPkg::instr_u word;
        @(posedge clk);
        stepModel();
        cycleCount++;
        #1;
        // fresh word every cycle, only the fetch one is used
        drawWord(word);
        reset = nextReset;
        run   = nextRun;
        instr = word;
        @(negedge clk);
        checkOutputs();
    endtask

    initial
    begin
        seed        = 80;
        reset       = 1'b0;
        run         = 1'b0;
        instr       = '0;
        mPhase      = cuCtrlPkg::phaseIdle;
        mWait       = 0;
        mClass      = cuIsaPkg::classIllegal;
        mAluOp      = 4'd0;
        mDest       = 5'd0;
        mWord       = 32'd0;
        lastPhase   = cuCtrlPkg::phaseIdle;
        insCycles   = 0;
        pcPulses    = 0;
        irPulses    = 0;
        insErrStart = 0;
        errors      = 0;
        checks      = 0;
        cycleCount  = 0;
        doneCount   = 0;
        testsFailed = 0;

        // reset low across three rising edges
        runCycle(1'b0, 1'b0);
        runCycle(1'b0, 1'b0);
        runCycle(1'b1, 1'b0);
        // run still low, machine has to sit in idle
        repeat (4)
        begin
            runCycle(1'b1, 1'b0);
        end
        if (errors == 0)
        begin
            $display("test reset and idle: pass");
        end
        else
        begin
            testsFailed++;
            $display("test reset and idle: fail");
        end

        while ((doneCount < numInstr) && (cycleCount < cycleLimit))
        begin
            runCycle(1'b1, 1'b1);
        end
        assert (doneCount == numInstr)
        else
        begin
            $display("timeout: %0d of %0d instructions finished within %0d cycles",
                     doneCount, numInstr, cycleLimit);
            errors++;
        end

        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 doneCount + 1, doneCount + 1 - testsFailed, testsFailed, checks, errors);
        if (errors == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
rtl/cuIsaPkg.sv
rtl/cuCtrlPkg.sv
rtl/instrDecoder.sv
rtl/accessTimer.sv
rtl/phaseSequencer.sv
rtl/controlWordGen.sv
rtl/controlUnitTop.sv
dv/tbControlUnit.sv

/* run.sh */
#!/bin/sh
# build and run the control unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tbControlUnit \
    -f verilog.f

out=$(./obj_dir/VtbControlUnit)
echo "$out"

if echo "$out" | grep -q "^Simulation PASSED$"; then
    exit 0
else
    exit 1
fi
